/* source/mmu_config_pkg.sv */
//##########################################################
// MMU configuration
// Page and ASID sizes, TLB geometry and the register map
// of the TLB management slave
//##########################################################
`default_nettype none

package mmu_config_pkg;
    // Translation sizes
    localparam int page_num_bits = 20;
    localparam int asid_width = 8;

    // TLB geometry
    localparam int tlb_entries = 64;
    localparam int tlb_ways = 4;

    // AXI4-Lite management port
    localparam int axi_addr_width = 5;
    localparam int axi_data_width = 32;

    // Register offsets, ppage also carries the flags in bits 24:20
    localparam logic [axi_addr_width-1:0] reg_vpage = 5'h00;
    localparam logic [axi_addr_width-1:0] reg_asid = 5'h04;
    localparam logic [axi_addr_width-1:0] reg_ppage = 5'h08;
    localparam logic [axi_addr_width-1:0] reg_command = 5'h0c;
endpackage

`default_nettype wire

/* source/tlb_types_pkg.sv */
//##########################################################
// TLB data types
// Page index, entry layout, command and response encodings
//##########################################################
`default_nettype none

package tlb_types_pkg;
    import mmu_config_pkg::*;

    typedef logic [page_num_bits-1:0] page_index_t;
    typedef logic [asid_width-1:0] asid_t;

    // Present is the low bit, matching bit 20 of the ppage register
    typedef struct packed {
        logic global_page;
        logic supervisor;
        logic writable;
        logic executable;
        logic present;
    } tlb_flags_t;

    // One storage word per way and set
    typedef struct packed {
        page_index_t vpage;
        asid_t       asid;
        page_index_t ppage;
        tlb_flags_t  flags;
    } tlb_entry_t;

    typedef enum logic [1:0] {
        tlb_cmd_update = 2'd1,
        tlb_cmd_invalidate = 2'd2,
        tlb_cmd_invalidate_all = 2'd3
    } tlb_cmd_e;

    typedef enum logic [1:0] {
        axi_resp_okay = 2'b00,
        axi_resp_slverr = 2'b10
    } axi_resp_e;
endpackage

`default_nettype wire

/* source/tlb_cmd_if.sv */
//##########################################################
// TLB command bus
// Lookups and management commands from the control block
//##########################################################
`default_nettype none

interface tlb_cmd_if
    import tlb_types_pkg::*;
();
    // At most one enable per cycle
    logic        lookup_en;
    logic        update_en;
    logic        invalidate_en;
    logic        invalidate_all_en;
    page_index_t vpage;
    asid_t       asid;

    // Only looked at with update_en
    tlb_entry_t  entry;

    modport ctrl (
        output lookup_en,
        output update_en,
        output invalidate_en,
        output invalidate_all_en,
        output vpage,
        output asid,
        output entry
    );

    modport tlb (
        input lookup_en,
        input update_en,
        input invalidate_en,
        input invalidate_all_en,
        input vpage,
        input asid,
        input entry
    );
endinterface

`default_nettype wire

/* source/sram_1r1w.sv */
//##########################################################
// Storage array, one read and one write port
// Registered read, new data on read-during-write
//##########################################################
`default_nettype none

module sram_1r1w
#(
    parameter int SIZE = 64,
    parameter int DATA_WIDTH = 32
)
(
    input  logic                    clk,
    input  logic                    read_en,
    input  logic [$clog2(SIZE)-1:0] read_addr,
    output logic [DATA_WIDTH-1:0]   read_data,
    input  logic                    write_en,
    input  logic [$clog2(SIZE)-1:0] write_addr,
    input  logic [DATA_WIDTH-1:0]   write_data
);
    logic [DATA_WIDTH-1:0] data [SIZE];

    always_ff @(posedge clk)
    begin
        if (write_en)
            data[write_addr] <= write_data;

        if (read_en)
        begin
            // Forward the word being written
            if (write_en && read_addr == write_addr)
                read_data <= write_data;
            else
                read_data <= data[read_addr];
        end
    end
endmodule

`default_nettype wire

/* source/tlb.sv */
//##########################################################
// Translation lookaside buffer
// Set-associative cache of page translations per ASID.
// Stage 1 reads all ways, stage 2 compares tags, answers
// lookups and writes back updates and invalidates
//##########################################################
`default_nettype none

module tlb
    import mmu_config_pkg::*, tlb_types_pkg::*;
#(
    parameter int NUM_ENTRIES = tlb_entries,
    parameter int NUM_WAYS = tlb_ways
)
(
    input  logic        clk,
    input  logic        reset,
    tlb_cmd_if.tlb      cmd,
    output logic        resp_valid,
    output logic        resp_hit,
    output page_index_t resp_ppage,
    output tlb_flags_t  resp_flags
);
    localparam int num_sets = NUM_ENTRIES / NUM_WAYS;
    localparam int set_bits = $clog2(num_sets);

    logic                read_en;
    logic [set_bits-1:0] read_set;
    logic [set_bits-1:0] write_set;
    logic                update_q;
    logic                invalidate_q;
    page_index_t         vpage_q;
    asid_t               asid_q;
    tlb_entry_t          entry_q;
    tlb_entry_t          way_entry [NUM_WAYS];
    logic [NUM_WAYS-1:0] way_hit;
    logic [NUM_WAYS-1:0] way_write;
    logic [NUM_WAYS-1:0] rr_way;

    // Stage 1
    assign read_en = cmd.lookup_en || cmd.update_en || cmd.invalidate_en;
    assign read_set = cmd.vpage[set_bits-1:0];
    assign write_set = vpage_q[set_bits-1:0];

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            resp_valid <= 1'b0;
            update_q <= 1'b0;
            invalidate_q <= 1'b0;
        end
        else
        begin
            resp_valid <= cmd.lookup_en;
            update_q <= cmd.update_en;
            invalidate_q <= cmd.invalidate_en;
        end
    end

    always_ff @(posedge clk)
    begin
        if (read_en)
        begin
            vpage_q <= cmd.vpage;
            asid_q <= cmd.asid;
        end
        if (cmd.update_en)
            entry_q <= cmd.entry;
    end

    for (genvar w = 0; w < NUM_WAYS; w++)
    begin : g_way
        logic [num_sets-1:0] valid_bits;
        logic                valid_q;

        // Data is only rewritten on update, invalidate touches the valid bit
        sram_1r1w #(
            .SIZE(num_sets),
            .DATA_WIDTH($bits(tlb_entry_t))
        ) i_sram (
            .clk(clk),
            .read_en(read_en),
            .read_addr(read_set),
            .read_data(way_entry[w]),
            .write_en(way_write[w] && update_q),
            .write_addr(write_set),
            .write_data(entry_q)
        );

        always_ff @(posedge clk, posedge reset)
        begin
            if (reset)
                valid_bits <= '0;
            else if (cmd.invalidate_all_en)
                valid_bits <= '0;
            else if (way_write[w])
                valid_bits[write_set] <= update_q;
        end

        // A stage 2 write to the set being read wins over the stored bit
        always_ff @(posedge clk, posedge reset)
        begin
            if (reset)
                valid_q <= 1'b0;
            else if (!read_en)
                valid_q <= 1'b0;
            else if (way_write[w] && write_set == read_set)
                valid_q <= update_q;
            else
                valid_q <= valid_bits[read_set];
        end

        assign way_hit[w] = valid_q && way_entry[w].vpage == vpage_q
            && (way_entry[w].asid == asid_q || way_entry[w].flags.global_page);
    end

    // Stage 2
    assign resp_hit = |way_hit;

    // Plain OR of the ways, no priority needed since at most one hits
    always_comb
    begin
        resp_ppage = '0;
        resp_flags = '0;
        for (int w = 0; w < NUM_WAYS; w++)
        begin
            if (way_hit[w])
            begin
                resp_ppage = resp_ppage | way_entry[w].ppage;
                resp_flags = resp_flags | way_entry[w].flags;
            end
        end
    end

    // Reuse the hit way so a page never sits in two ways
    always_comb
    begin
        if (update_q || invalidate_q)
            way_write = resp_hit ? way_hit : rr_way;
        else
            way_write = '0;
    end

    // Victim pointer shared by all sets
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            rr_way <= NUM_WAYS'(1);
        else if (update_q)
            rr_way <= {rr_way[NUM_WAYS-2:0], rr_way[NUM_WAYS-1]};
    end
endmodule

`default_nettype wire

/* source/tlb_control.sv */
//##########################################################
// TLB management slave
// AXI4-Lite staging registers and command register.
// Lookups pass straight through, a management command
// goes out in the first cycle without a lookup
//##########################################################
`default_nettype none

module tlb_control
    import mmu_config_pkg::*, tlb_types_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic [axi_addr_width-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [axi_data_width-1:0] wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output axi_resp_e                 bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [axi_addr_width-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [axi_data_width-1:0] rdata,
    output axi_resp_e                 rresp,
    output logic                      rvalid,
    input  logic                      rready,
    input  logic                      lookup_valid,
    input  page_index_t               lookup_vpage,
    input  asid_t                     lookup_asid,
    tlb_cmd_if.ctrl                   cmd
);
    page_index_t vpage_reg;
    asid_t       asid_reg;
    page_index_t ppage_reg;
    tlb_flags_t  flags_reg;
    tlb_cmd_e    pend_cmd;
    logic        pend_valid;
    logic        write_start;
    logic        write_fire;
    logic        read_fire;
    logic        cmd_write;
    logic        issue;
    axi_resp_e   write_resp;

    assign write_start = awvalid && wvalid && !awready && !bvalid && !pend_valid;
    assign write_fire = awready && awvalid && wvalid;
    assign read_fire = arready && arvalid;
    assign cmd_write = awaddr == reg_command
        && wdata inside {tlb_cmd_update, tlb_cmd_invalidate, tlb_cmd_invalidate_all};
    assign issue = pend_valid && !lookup_valid;

    // Valid commands are answered at issue
    always_comb
    begin
        case (awaddr)
            reg_vpage, reg_asid, reg_ppage: write_resp = axi_resp_okay;
            default: write_resp = axi_resp_slverr;
        endcase
    end

    // Write channel and pending command
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            awready <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            bresp <= axi_resp_okay;
            pend_valid <= 1'b0;
            pend_cmd <= tlb_cmd_update;
        end
        else
        begin
            awready <= write_start;
            wready <= write_start;
            if (write_fire && cmd_write)
            begin
                // B response held back until the TLB takes the command
                pend_valid <= 1'b1;
                pend_cmd <= tlb_cmd_e'(wdata[$bits(tlb_cmd_e)-1:0]);
            end
            else if (write_fire)
            begin
                bvalid <= 1'b1;
                bresp <= write_resp;
            end
            else if (issue)
            begin
                pend_valid <= 1'b0;
                bvalid <= 1'b1;
                bresp <= axi_resp_okay;
            end
            else if (bvalid && bready)
                bvalid <= 1'b0;
        end
    end

    // Staging registers
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            vpage_reg <= '0;
            asid_reg <= '0;
            ppage_reg <= '0;
            flags_reg <= '0;
        end
        else if (write_fire)
        begin
            case (awaddr)
                reg_vpage: vpage_reg <= wdata[page_num_bits-1:0];
                reg_asid: asid_reg <= wdata[asid_width-1:0];
                reg_ppage:
                begin
                    ppage_reg <= wdata[page_num_bits-1:0];
                    flags_reg <= wdata[page_num_bits +: $bits(tlb_flags_t)];
                end
                default: ;
            endcase
        end
    end

    // Read channel
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            arready <= 1'b0;
            rvalid <= 1'b0;
        end
        else
        begin
            arready <= arvalid && !arready && !rvalid;
            if (read_fire)
                rvalid <= 1'b1;
            else if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (read_fire)
        begin
            rresp <= axi_resp_okay;
            case (araddr)
                reg_vpage: rdata <= axi_data_width'(vpage_reg);
                reg_asid: rdata <= axi_data_width'(asid_reg);
                reg_ppage: rdata <= axi_data_width'({flags_reg, ppage_reg});
                reg_command: rdata <= '0;
                default:
                begin
                    rdata <= '0;
                    rresp <= axi_resp_slverr;
                end
            endcase
        end
    end

    // Lookups always take the bus
    assign cmd.lookup_en = lookup_valid;
    assign cmd.update_en = issue && pend_cmd == tlb_cmd_update;
    assign cmd.invalidate_en = issue && pend_cmd == tlb_cmd_invalidate;
    assign cmd.invalidate_all_en = issue && pend_cmd == tlb_cmd_invalidate_all;
    assign cmd.vpage = lookup_valid ? lookup_vpage : vpage_reg;
    assign cmd.asid = lookup_valid ? lookup_asid : asid_reg;
    assign cmd.entry = '{vpage: vpage_reg, asid: asid_reg, ppage: ppage_reg, flags: flags_reg};
endmodule

`default_nettype wire

/* source/mmu_tlb_top.sv */
//##########################################################
// MMU TLB subsystem
// AXI4-Lite management slave in front of the TLB, with a
// one-cycle lookup port for the pipeline
//##########################################################
`default_nettype none

module mmu_tlb_top
    import mmu_config_pkg::*, tlb_types_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    // AXI4-Lite management slave
    input  logic [axi_addr_width-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [axi_data_width-1:0] wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output axi_resp_e                 bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [axi_addr_width-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [axi_data_width-1:0] rdata,
    output axi_resp_e                 rresp,
    output logic                      rvalid,
    input  logic                      rready,

    // Lookup request, always accepted
    input  logic                      lookup_valid,
    input  page_index_t               lookup_vpage,
    input  asid_t                     lookup_asid,

    // Lookup response, one cycle later
    output logic                      resp_valid,
    output logic                      resp_hit,
    output page_index_t               resp_ppage,
    output tlb_flags_t                resp_flags
);
    tlb_cmd_if cmd_bus ();

    tlb_control i_control (
        .cmd(cmd_bus),
        .*
    );

    tlb #(
        .NUM_ENTRIES(tlb_entries),
        .NUM_WAYS(tlb_ways)
    ) i_tlb (
        .cmd(cmd_bus),
        .*
    );
endmodule

`default_nettype wire

/* tests/tlb_checker.sv */
//##########################################################
// TLB protocol checker
// Bound into the TLB, watches command enables, way hits
// and the lookup response timing
//##########################################################
`default_nettype none

module tlb_checker
#(
    parameter int NUM_WAYS = 4
)
(
    input logic                clk,
    input logic                reset,
    input logic                lookup_en,
    input logic                update_en,
    input logic                invalidate_en,
    input logic                invalidate_all_en,
    input logic [NUM_WAYS-1:0] way_hit,
    input logic                resp_valid
);
    // Count of failed assertions
    int unsigned fail_count = 0;

    a_one_command: assert property (@(posedge clk) disable iff (reset)
        $onehot0({lookup_en, update_en, invalidate_en, invalidate_all_en}))
    else
    begin
        fail_count++;
        $error("More than one TLB command enable high");
    end

    a_one_way: assert property (@(posedge clk) disable iff (reset) $onehot0(way_hit))
    else
    begin
        fail_count++;
        $error("More than one TLB way hits");
    end

    // One response per lookup and one cycle later
    a_resp_timing: assert property (@(posedge clk) disable iff (reset)
        lookup_en |=> resp_valid)
    else
    begin
        fail_count++;
        $error("Lookup not answered one cycle later");
    end

    a_no_spurious: assert property (@(posedge clk) disable iff (reset)
        !lookup_en |=> !resp_valid)
    else
    begin
        fail_count++;
        $error("Response without a lookup");
    end
endmodule

`default_nettype wire

/* tests/tlb_tb.sv */
//##########################################################
// TLB subsystem testbench
// Directed tests over the AXI4-Lite management slave and
// the lookup port of the MMU TLB
//##########################################################
`default_nettype none

module tlb_tb
    import mmu_config_pkg::*, tlb_types_pkg::*;
();
    localparam int test_steps = 72;
    localparam int watchdog_cycles = test_steps * 200;
    localparam int handshake_limit = 50;

    localparam tlb_flags_t rw_flags = '{global_page: 1'b0, supervisor: 1'b0,
        writable: 1'b1, executable: 1'b0, present: 1'b1};
    localparam tlb_flags_t global_flags = '{global_page: 1'b1, supervisor: 1'b0,
        writable: 1'b0, executable: 1'b1, present: 1'b1};

    logic                      clk;
    logic                      reset;
    logic [axi_addr_width-1:0] awaddr;
    logic                      awvalid;
    logic                      awready;
    logic [axi_data_width-1:0] wdata;
    logic                      wvalid;
    logic                      wready;
    axi_resp_e                 bresp;
    logic                      bvalid;
    logic                      bready;
    logic [axi_addr_width-1:0] araddr;
    logic                      arvalid;
    logic                      arready;
    logic [axi_data_width-1:0] rdata;
    axi_resp_e                 rresp;
    logic                      rvalid;
    logic                      rready;
    logic                      lookup_valid;
    page_index_t               lookup_vpage;
    asid_t                     lookup_asid;
    logic                      resp_valid;
    logic                      resp_hit;
    page_index_t               resp_ppage;
    tlb_flags_t                resp_flags;

    logic [31:0] lfsr_state;
    page_index_t page_a;
    page_index_t page_b;

    mmu_tlb_top i_dut (.*);

    bind tlb tlb_checker #(
        .NUM_WAYS(NUM_WAYS)
    ) i_checker (
        .clk(clk),
        .reset(reset),
        .lookup_en(cmd.lookup_en),
        .update_en(cmd.update_en),
        .invalidate_en(cmd.invalidate_en),
        .invalidate_all_en(cmd.invalidate_all_en),
        .way_hit(way_hit),
        .resp_valid(resp_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
        stop_run();
    end

    initial
    begin
        wait (i_dut.i_tlb.i_checker.fail_count != 0);
        $display("TLB checker assertion failed at %0t", $time);
        stop_run();
    end

    task automatic stop_run();
        $display(">>> FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] random_bits(int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    // Flags sit above the page in the ppage register
    function automatic logic [axi_data_width-1:0] ppage_word(page_index_t ppage,
                                                               tlb_flags_t flags);
        logic [axi_data_width-1:0] word;
        word = axi_data_width'(ppage);
        word[page_num_bits] = flags.present;
        word[page_num_bits + 1] = flags.executable;
        word[page_num_bits + 2] = flags.writable;
        word[page_num_bits + 3] = flags.supervisor;
        word[page_num_bits + 4] = flags.global_page;
        return word;
    endfunction

    task automatic count_wait(inout int waited, input string what);
        waited++;
        if (waited > handshake_limit)
        begin
            $display("Timeout waiting for %s from the DUT at %0t", what, $time);
            stop_run();
        end
    endtask

    task automatic check_hit(logic exp_hit, page_index_t exp_ppage, tlb_flags_t exp_flags);
        if (resp_hit !== exp_hit)
        begin
            $display("ERROR at %0t: resp_hit is %b, expected %b", $time, resp_hit, exp_hit);
            stop_run();
        end
        if (exp_hit && resp_ppage !== exp_ppage)
        begin
            $display("ERROR at %0t: resp_ppage is %h, expected %h", $time, resp_ppage, exp_ppage);
            stop_run();
        end
        if (exp_hit && resp_flags !== exp_flags)
        begin
            $display("ERROR at %0t: resp_flags is %b, expected %b", $time, resp_flags, exp_flags);
            stop_run();
        end
    endtask

    task automatic check_resp(string name, axi_resp_e got, axi_resp_e exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_data(string name, logic [axi_data_width-1:0] got,
                              logic [axi_data_width-1:0] exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic axi_write(logic [axi_addr_width-1:0] addr, logic [axi_data_width-1:0] data,
                             output axi_resp_e resp);
        int waited;
        @(posedge clk);
        awaddr <= addr;
        awvalid <= 1'b1;
        wdata <= data;
        wvalid <= 1'b1;
        waited = 0;
        do
        begin
            @(negedge clk);
            count_wait(waited, "awready");
        end
        while (!(awready && wready));
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        waited = 0;
        do
        begin
            @(negedge clk);
            count_wait(waited, "bvalid");
        end
        while (!bvalid);
        resp = bresp;
    endtask

    task automatic axi_read(logic [axi_addr_width-1:0] addr,
                            output logic [axi_data_width-1:0] data, output axi_resp_e resp);
        int waited;
        @(posedge clk);
        araddr <= addr;
        arvalid <= 1'b1;
        waited = 0;
        do
        begin
            @(negedge clk);
            count_wait(waited, "arready");
        end
        while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        waited = 0;
        do
        begin
            @(negedge clk);
            count_wait(waited, "rvalid");
        end
        while (!rvalid);
        data = rdata;
        resp = rresp;
    endtask

    task automatic write_checked(logic [axi_addr_width-1:0] addr,
                                 logic [axi_data_width-1:0] data, axi_resp_e exp_resp);
        axi_resp_e resp;
        axi_write(addr, data, resp);
        check_resp("bresp", resp, exp_resp);
    endtask

    task automatic read_checked(logic [axi_addr_width-1:0] addr,
                                logic [axi_data_width-1:0] exp_data, axi_resp_e exp_resp);
        logic [axi_data_width-1:0] data;
        axi_resp_e                 resp;
        axi_read(addr, data, resp);
        check_resp("rresp", resp, exp_resp);
        check_data("rdata", data, exp_data);
    endtask

    task automatic select_page(page_index_t vpage, asid_t asid);
        write_checked(reg_vpage, axi_data_width'(vpage), axi_resp_okay);
        write_checked(reg_asid, axi_data_width'(asid), axi_resp_okay);
    endtask

    task automatic stage_entry(page_index_t vpage, asid_t asid, page_index_t ppage,
                               tlb_flags_t flags);
        select_page(vpage, asid);
        write_checked(reg_ppage, ppage_word(ppage, flags), axi_resp_okay);
    endtask

    // B response marks the command as taken by the TLB
    task automatic issue_cmd(tlb_cmd_e command);
        write_checked(reg_command, axi_data_width'(command), axi_resp_okay);
    endtask

    task automatic lookup_check(page_index_t vpage, asid_t asid, logic exp_hit,
                                page_index_t exp_ppage, tlb_flags_t exp_flags);
        @(posedge clk);
        lookup_valid <= 1'b1;
        lookup_vpage <= vpage;
        lookup_asid <= asid;
        @(posedge clk);
        lookup_valid <= 1'b0;
        @(negedge clk);
        if (!resp_valid)
        begin
            $display("No lookup response one cycle after the request at %0t", $time);
            stop_run();
        end
        check_hit(exp_hit, exp_ppage, exp_flags);
    endtask

    task automatic miss_after_reset();
        for (int i = 0; i < 4; i++)
            lookup_check(page_index_t'(random_bits(20)), asid_t'(random_bits(8)), 1'b0, '0, '0);
    endtask

    task automatic update_then_hit();
        page_index_t ppage;
        page_a = page_index_t'(random_bits(20));
        ppage = page_index_t'(random_bits(20));
        stage_entry(page_a, 8'h12, ppage, rw_flags);
        issue_cmd(tlb_cmd_update);
        lookup_check(page_a, 8'h12, 1'b1, ppage, rw_flags);
    endtask

    task automatic asid_and_global();
        page_index_t ppage;
        lookup_check(page_a, 8'h34, 1'b0, '0, '0);
        // Other tag in the set of page_a
        page_b = page_a ^ 20'h00100;
        ppage = page_index_t'(random_bits(20));
        stage_entry(page_b, 8'h12, ppage, global_flags);
        issue_cmd(tlb_cmd_update);
        lookup_check(page_b, 8'h34, 1'b1, ppage, global_flags);
        lookup_check(page_b, 8'h12, 1'b1, ppage, global_flags);
    endtask

    task automatic invalidate_pages();
        page_index_t page_c;
        page_index_t page_d;
        page_index_t ppage_d;
        page_c = page_index_t'(random_bits(20));
        page_d = page_c ^ 20'h10000;
        ppage_d = page_index_t'(random_bits(20));
        stage_entry(page_c, 8'h07, page_index_t'(random_bits(20)), rw_flags);
        issue_cmd(tlb_cmd_update);
        stage_entry(page_d, 8'h07, ppage_d, rw_flags);
        issue_cmd(tlb_cmd_update);
        select_page(page_c, 8'h07);
        issue_cmd(tlb_cmd_invalidate);
        lookup_check(page_c, 8'h07, 1'b0, '0, '0);
        lookup_check(page_d, 8'h07, 1'b1, ppage_d, rw_flags);

        issue_cmd(tlb_cmd_invalidate_all);
        lookup_check(page_a, 8'h12, 1'b0, '0, '0);
        lookup_check(page_b, 8'h34, 1'b0, '0, '0);
        lookup_check(page_d, 8'h07, 1'b0, '0, '0);
    endtask

    // Five pages into one set of four ways
    task automatic round_robin_evict();
        page_index_t pages [5];
        page_index_t ppages [5];
        logic [3:0]  set;
        set = 4'(random_bits(4));
        for (int i = 0; i < 5; i++)
        begin
            pages[i] = {12'(random_bits(12)), 4'(i), set};
            ppages[i] = page_index_t'(random_bits(20));
            stage_entry(pages[i], 8'h21, ppages[i], rw_flags);
            issue_cmd(tlb_cmd_update);
        end
        lookup_check(pages[0], 8'h21, 1'b0, '0, '0);
        for (int i = 1; i < 5; i++)
            lookup_check(pages[i], 8'h21, 1'b1, ppages[i], rw_flags);
    endtask

    task automatic register_access();
        logic [axi_data_width-1:0] word;
        word = ppage_word(20'h3c0de, '{global_page: 1'b1, supervisor: 1'b1,
            writable: 1'b0, executable: 1'b1, present: 1'b1});
        write_checked(reg_vpage, 32'h000abcde, axi_resp_okay);
        write_checked(reg_asid, 32'h0000005a, axi_resp_okay);
        write_checked(reg_ppage, word, axi_resp_okay);
        read_checked(reg_vpage, 32'h000abcde, axi_resp_okay);
        read_checked(reg_asid, 32'h0000005a, axi_resp_okay);
        read_checked(reg_ppage, word, axi_resp_okay);
        read_checked(reg_command, '0, axi_resp_okay);

        write_checked(reg_command, 32'h0, axi_resp_slverr);
        write_checked(reg_command, 32'h7, axi_resp_slverr);
        write_checked(5'h10, 32'h1, axi_resp_slverr);
        read_checked(5'h14, '0, axi_resp_slverr);
    endtask

    initial
    begin
        lfsr_state = 32'h191d7335;
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        lookup_valid = 1'b0;
        lookup_vpage = '0;
        lookup_asid = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        miss_after_reset();
        update_then_hit();
        asid_and_global();
        invalidate_pages();
        round_robin_evict();
        register_access();

        repeat (2) @(posedge clk);
        if (i_dut.i_tlb.i_checker.fail_count == 0)
        begin
            $display(">>> PASS");
            $finish;
        end
        else
        begin
            $display("Checker assertions failed %0d times", i_dut.i_tlb.i_checker.fail_count);
            stop_run();
        end
    end
endmodule

`default_nettype wire

/* mmu_tlb.f */
source/mmu_config_pkg.sv
source/tlb_types_pkg.sv
source/tlb_cmd_if.sv
source/sram_1r1w.sv
source/tlb.sv
source/tlb_control.sv
source/mmu_tlb_top.sv
tests/tlb_checker.sv
tests/tlb_tb.sv

/* Bender.yml */
package:
  name: mmu_tlb

sources:
  - source/mmu_config_pkg.sv
  - source/tlb_types_pkg.sv
  - source/tlb_cmd_if.sv
  - source/sram_1r1w.sv
  - source/tlb.sv
  - source/tlb_control.sv
  - source/mmu_tlb_top.sv
  - target: test
    files:
      - tests/tlb_checker.sv
      - tests/tlb_tb.sv
